//--- ds1620_ctrl.f
+incdir+source
source/ds1620_pkg.sv
source/ds1620_wire_xfer.sv
source/ds1620_sequencer.sv
source/ds1620_host_regs.sv
source/ds1620_thermostat.sv
source/ds1620_ctrl.sv
tb/ds1620_ctrl_sva.sv
tb/ds1620_model.sv
tb/tb_ds1620_ctrl.sv

//--- tb/tb_ds1620_ctrl.sv
`timescale 1ns/1ps

module tb_ds1620_ctrl;

  localparam int WRITE_WAIT  = 40;
  localparam int POLL_PERIOD = 200;
  // 16 CLK_32 cycles per bit tick
  localparam int POLL_CYCLES = POLL_PERIOD * 16;
  // Whole run spans roughly fifteen poll periods, wide margin on top
  localparam int TIMEOUT_CYCLES = 125 * POLL_CYCLES;
  localparam logic [15:0] HOST_ADR = 16'hC000;

  logic        CLK_32;
  logic        RESET;
  logic        ack_access;
  logic        we;
  logic [15:0] adr;
  logic [15:0] dq_temp;
  logic        read_done;
  logic        thermostat;
  logic        ds_clk;
  logic        ds_rst;
  wire         dq;
  int          cycle_count;

  pullup (dq);

  ds1620_ctrl #(
    .write_wait  (WRITE_WAIT),
    .poll_period (POLL_PERIOD)
  ) dut (
    .CLK_32     (CLK_32),
    .RESET      (RESET),
    .dq         (dq),
    .ds_clk     (ds_clk),
    .ds_rst     (ds_rst),
    .ack_access (ack_access),
    .we         (we),
    .adr        (adr),
    .dq_temp    (dq_temp),
    .read_done  (read_done),
    .thermostat (thermostat)
  );

  ds1620_model model (
    .rst (ds_rst),
    .clk (ds_clk),
    .dq  (dq)
  );

  bind ds1620_wire_xfer ds1620_ctrl_sva sva (
    .CLK_32 (CLK_32),
    .RESET  (RESET),
    .pins   (pins)
  );

  initial begin
    CLK_32 = 1'b0;
    forever #5 CLK_32 = ~CLK_32;
  end

  //////////////////////////////////////////////////////////////////////
  // Common tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // Inputs change and outputs are sampled 1 ns after the edge
  task automatic step();
    @(posedge CLK_32);
    #1;
  endtask

  always @(posedge CLK_32) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // Stop at the first wire protocol assertion failure
  always @(posedge CLK_32) begin
    if (dut.u_xfer.sva.failures != 0) begin
      $display("Wire protocol assertion failed %0d times", dut.u_xfer.sva.failures);
      abort_run();
    end
  end

  task automatic host_read(output logic [15:0] value);
    ack_access = 1'b1;
    we         = 1'b0;
    adr        = HOST_ADR;
    do step(); while (!read_done);
    value      = dq_temp;
    ack_access = 1'b0;
    step();
    check("read_done", read_done, 1'b0);
  endtask

  task automatic host_write();
    ack_access = 1'b1;
    we         = 1'b1;
    adr        = HOST_ADR;
    do step(); while (!read_done);
    ack_access = 1'b0;
    we         = 1'b0;
    step();
    check("read_done", read_done, 1'b0);
  endtask

  // Status word: bit 10 busy, bit 9 init_ok
  task automatic wait_idle(output logic [15:0] value);
    value = 16'h0400;
    while (value[10]) begin
      repeat (16) step();
      host_read(value);
    end
  endtask

  // Until a new temperature read has finished and reached the outputs
  task automatic wait_poll_read();
    int start_size;
    start_size = model.cmd_log.size();
    while (model.cmd_log.size() <= start_size ||
           model.cmd_log[model.cmd_log.size()-1] != 8'hAA) begin
      step();
    end
    repeat (3) step();
  endtask

  task automatic apply_temp(input logic [8:0] value);
    model.temp_value = value;
    wait_poll_read();
  endtask

  task automatic check_init_log(input int base);
    logic [7:0] exp_cmd [5];
    logic [8:0] exp_data [5];
    exp_cmd  = '{8'h0C, 8'hEE, 8'h01, 8'h02, 8'hAC};
    exp_data = '{9'h00A, 9'd0, 9'd180, 9'd170, 9'd0};
    if (model.cmd_log.size() < base + 5) begin
      $display("Model saw only %0d commands of the init sequence",
               model.cmd_log.size() - base);
      abort_run();
    end
    for (int i = 0; i < 5; i++) begin
      check($sformatf("cmd_log[%0d]", base + i), model.cmd_log[base+i], exp_cmd[i]);
      check($sformatf("data_log[%0d]", base + i), model.data_log[base+i], exp_data[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_init_order();
    logic [15:0] value;
    wait_idle(value);
    check("dq_temp", value, 16'h0200);
    check("cmd_log size", model.cmd_log.size(), 5);
    check_init_log(0);
  endtask

  task automatic test_periodic_read();
    logic [15:0] value;
    logic [8:0]  temp;
    wait_poll_read();
    temp = 9'($urandom_range(255, 0));
    model.temp_value = temp;
    wait_poll_read();
    host_read(value);
    check("dq_temp", value, {5'b0, 1'b0, 1'b1, temp});
  endtask

  // Starts inside a poll wait, so the new value is read whole
  task automatic test_thermostat();
    apply_temp(9'd182);
    check("thermostat", thermostat, 1'b1);
    apply_temp(9'd176);
    check("thermostat", thermostat, 1'b1);
    apply_temp(9'd168);
    check("thermostat", thermostat, 1'b0);
    // Bits 7:1 above TH, sign set
    apply_temp(9'h1FE);
    check("thermostat", thermostat, 1'b0);
  endtask

  task automatic test_reload();
    logic [15:0] value;
    int          base;
    base = model.cmd_log.size();
    host_write();
    while (model.cmd_log.size() == base) step();
    host_read(value);
    check("busy", value[10], 1'b1);
    // Ignored while busy
    host_write();
    wait_idle(value);
    check("init_ok", value[9], 1'b1);
    wait_poll_read();
    check("cmd_log size", model.cmd_log.size(), base + 6);
    check_init_log(base);
    check("cmd_log last", model.cmd_log[base+5], 8'hAA);
  endtask

  task automatic test_bad_readback();
    logic [15:0] value;
    int          base;
    model.config_value = 8'h00;
    base = model.cmd_log.size();
    host_write();
    wait_idle(value);
    check("init_ok", value[9], 1'b0);
    check_init_log(base);
    base = model.cmd_log.size();
    repeat (2 * POLL_CYCLES) step();
    check("cmd_log size", model.cmd_log.size(), base);
  endtask

  initial begin
    void'($urandom(32'hcf75));
    cycle_count = 0;
    RESET       = 1'b1;
    ack_access  = 1'b0;
    we          = 1'b0;
    adr         = 16'h0000;
    repeat (16) @(posedge CLK_32);
    #1;
    RESET = 1'b0;

    test_init_order();
    test_periodic_read();
    test_thermostat();
    test_reload();
    test_bad_readback();

    if (dut.u_xfer.sva.failures == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Wire protocol assertions failed %0d times", dut.u_xfer.sva.failures);
      abort_run();
    end
  end

endmodule

//--- tb/ds1620_model.sv
`timescale 1ns/1ps

module ds1620_model (
  input logic rst,
  input logic clk,
  inout wire  dq
);

  logic [7:0] config_value;
  logic [8:0] temp_value;
  logic [7:0] cmd_log [$];
  logic [8:0] data_log [$];
  logic [7:0] cmd_sr;
  logic [8:0] data_sr;
  logic [8:0] out_sr;
  logic       in_xfer;
  logic       drive;
  logic       dq_drv;
  int         bit_cnt;

  assign dq = drive ? dq_drv : 1'bz;

  initial begin
    config_value = 8'h0A;
    temp_value   = 9'd0;
    in_xfer      = 1'b0;
    drive        = 1'b0;
    dq_drv       = 1'b0;
    bit_cnt      = 0;
  end

  function automatic logic is_read(input logic [7:0] cmd);
    return (cmd == 8'hAC) || (cmd == 8'hAA);
  endfunction

  always @(posedge rst) begin
    in_xfer = 1'b1;
    bit_cnt = 0;
    cmd_sr  = 8'd0;
    data_sr = 9'd0;
    out_sr  = 9'd0;
  end

  // End of a transfer, log what was exchanged
  always @(negedge rst) begin
    if (in_xfer) begin
      cmd_log.push_back(cmd_sr);
      data_log.push_back(data_sr);
    end
    in_xfer = 1'b0;
    drive   = 1'b0;
  end

  // Bits are taken on the rising clock edge, LSB first
  always @(posedge clk) begin
    if (rst) begin
      if (bit_cnt < 8) begin
        cmd_sr[bit_cnt] = dq;
      end else if (!is_read(cmd_sr) && bit_cnt < 17) begin
        data_sr[bit_cnt-8] = dq;
      end
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8) begin
        out_sr = (cmd_sr == 8'hAC) ? {1'b0, config_value} : temp_value;
      end
    end
  end

  // Read data goes out on the falling edge
  always @(negedge clk) begin
    if (rst && bit_cnt >= 8 && bit_cnt < 17 && is_read(cmd_sr)) begin
      drive  = 1'b1;
      dq_drv = out_sr[bit_cnt-8];
    end
  end

endmodule

//--- tb/ds1620_ctrl_sva.sv
`timescale 1ns/1ps

module ds1620_ctrl_sva (
  input logic                   CLK_32,
  input logic                   RESET,
  input ds1620_pkg::wire_pins_t pins
);

  int failures;

  // DQ may only be driven inside a transfer
  oe_inside_rst: assert property (@(posedge CLK_32) disable iff (RESET)
    !pins.rst |-> !pins.dq_oe)
    else begin
      $error("dq_oe high while rst is low");
      failures++;
    end

  clk_high_rst_rise: assert property (@(posedge CLK_32) disable iff (RESET)
    $rose(pins.rst) |-> pins.clk)
    else begin
      $error("clk low when rst rose");
      failures++;
    end

  clk_high_rst_fall: assert property (@(posedge CLK_32) disable iff (RESET)
    $fell(pins.rst) |-> pins.clk)
    else begin
      $error("clk low when rst fell");
      failures++;
    end

endmodule

//--- source/ds1620_ctrl.sv
`timescale 1ns/1ps
`include "ds1620_defines.svh"

module ds1620_ctrl #(
  parameter int write_wait  = `DS_WRITE_WAIT,
  parameter int poll_period = `DS_POLL_PERIOD
) (
  input  logic        CLK_32,
  input  logic        RESET,
  inout  wire         dq,
  output logic        ds_clk,
  output logic        ds_rst,
  input  logic        ack_access,
  input  logic        we,
  input  logic [15:0] adr,
  output logic [15:0] dq_temp,
  output logic        read_done,
  output logic        thermostat
);

  ds1620_pkg::xfer_req_t    xfer_req;
  ds1620_pkg::wire_pins_t   pins;
  ds1620_pkg::status_t      status;
  ds1620_pkg::host_req_t    host;
  logic                     xfer_start;
  logic                     xfer_busy;
  logic                     xfer_done;
  logic [`DS_TEMP_BITS-1:0] xfer_rdata;
  logic                     temp_valid;
  logic                     reload;

  //////////////////////////////////////////////////////////////////////
  // Pins
  //////////////////////////////////////////////////////////////////////

  assign dq     = pins.dq_oe ? pins.dq_out : 1'bz;
  assign ds_clk = pins.clk;
  assign ds_rst = pins.rst;
  assign host   = '{ack: ack_access, we: we, sel: adr[15:13]};

  ds1620_wire_xfer u_xfer (
    .CLK_32 (CLK_32),
    .RESET  (RESET),
    .start  (xfer_start),
    .req    (xfer_req),
    .dq_in  (dq),
    .busy   (xfer_busy),
    .done   (xfer_done),
    .rdata  (xfer_rdata),
    .pins   (pins)
  );

  ds1620_sequencer #(
    .write_wait  (write_wait),
    .poll_period (poll_period)
  ) u_seq (
    .CLK_32     (CLK_32),
    .RESET      (RESET),
    .reload     (reload),
    .xfer_busy  (xfer_busy),
    .xfer_done  (xfer_done),
    .xfer_rdata (xfer_rdata),
    .start      (xfer_start),
    .req        (xfer_req),
    .status     (status),
    .temp_valid (temp_valid)
  );

  ds1620_host_regs u_host (
    .CLK_32    (CLK_32),
    .RESET     (RESET),
    .host      (host),
    .status    (status),
    .reload    (reload),
    .read_done (read_done),
    .dq_temp   (dq_temp)
  );

  ds1620_thermostat u_thermo (
    .CLK_32     (CLK_32),
    .RESET      (RESET),
    .temp_valid (temp_valid),
    .temp       (status.temp),
    .thermostat (thermostat)
  );

endmodule

//--- source/ds1620_thermostat.sv
`timescale 1ns/1ps
`include "ds1620_defines.svh"

module ds1620_thermostat (
  input  logic                     CLK_32,
  input  logic                     RESET,
  input  logic                     temp_valid,
  input  logic [`DS_TEMP_BITS-1:0] temp,
  output logic                     thermostat
);

  localparam logic [`DS_TEMP_BITS-1:0] TH = `DS_TH_LIMIT;
  localparam logic [`DS_TEMP_BITS-1:0] TL = `DS_TL_LIMIT;

  // Whole degrees compared, negative readings ignored
  always_ff @(posedge CLK_32 or posedge RESET) begin
    if (RESET) begin
      thermostat <= 1'b0;
    end else if (temp_valid && !temp[8]) begin
      if (temp[7:1] >= TH[7:1]) begin
        thermostat <= 1'b1;
      end else if (temp[7:1] <= TL[7:1]) begin
        thermostat <= 1'b0;
      end
    end
  end

endmodule

//--- source/ds1620_host_regs.sv
`timescale 1ns/1ps
`include "ds1620_defines.svh"

module ds1620_host_regs (
  input  logic                  CLK_32,
  input  logic                  RESET,
  input  ds1620_pkg::host_req_t host,
  input  ds1620_pkg::status_t   status,
  output logic                  reload,
  output logic                  read_done,
  output logic [15:0]           dq_temp
);

  logic hit;

  // First cycle of an access to this register
  assign hit = host.ack && (host.sel == `DS_HOST_SELECT) && !read_done;

  always_ff @(posedge CLK_32 or posedge RESET) begin
    if (RESET) begin
      reload    <= 1'b0;
      read_done <= 1'b0;
      dq_temp   <= '0;
    end else begin
      reload <= 1'b0;
      if (!host.ack) begin
        read_done <= 1'b0;
      end else if (hit) begin
        read_done <= 1'b1;
        if (host.we) begin
          // Write while busy is only acknowledged
          reload <= !status.busy;
        end else begin
          dq_temp <= {5'b0, status.busy, status.init_ok, status.temp};
        end
      end
    end
  end

endmodule

//--- source/ds1620_sequencer.sv
`timescale 1ns/1ps
`include "ds1620_defines.svh"

module ds1620_sequencer #(
  parameter int write_wait  = `DS_WRITE_WAIT,
  parameter int poll_period = `DS_POLL_PERIOD
) (
  input  logic                     CLK_32,
  input  logic                     RESET,
  input  logic                     reload,
  input  logic                     xfer_busy,
  input  logic                     xfer_done,
  input  logic [`DS_TEMP_BITS-1:0] xfer_rdata,
  output logic                     start,
  output ds1620_pkg::xfer_req_t    req,
  output ds1620_pkg::status_t      status,
  output logic                     temp_valid
);

  // Waits are given in ticks, counted here in CLK_32 cycles
  localparam int SETTLE_CYC = write_wait * `DS_TICK_DIV;
  localparam int POLL_CYC   = poll_period * `DS_TICK_DIV;
  localparam int MAX_CYC    = (SETTLE_CYC > POLL_CYC) ? SETTLE_CYC : POLL_CYC;
  localparam int CNT_W      = $clog2(MAX_CYC + 1);

  ds1620_pkg::seq_state_e   state;
  ds1620_pkg::seq_state_e   after_settle;
  logic [CNT_W-1:0]         wait_cnt;
  logic                     issued;
  logic                     cmd_state;
  logic                     busy;
  logic                     cfg_match;
  logic                     init_done;
  logic                     init_ok;
  logic [`DS_TEMP_BITS-1:0] temp;

  //////////////////////////////////////////////////////////////////////
  // Transfer request per state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd_state = 1'b1;
    req = '{ds1620_pkg::CMD_READ_TEMP, ds1620_pkg::DIR_READ, 4'd9, 9'd0};
    case (state)
      ds1620_pkg::ST_CONFIG: begin
        req = '{ds1620_pkg::CMD_WRITE_CONFIG, ds1620_pkg::DIR_WRITE, 4'd8,
                9'(`DS_CONFIG_VALUE)};
      end
      ds1620_pkg::ST_CONVERT: begin
        req = '{ds1620_pkg::CMD_START_CONVERT, ds1620_pkg::DIR_NONE, 4'd0, 9'd0};
      end
      ds1620_pkg::ST_TH: begin
        req = '{ds1620_pkg::CMD_WRITE_TH, ds1620_pkg::DIR_WRITE, 4'd9, `DS_TH_LIMIT};
      end
      ds1620_pkg::ST_TL: begin
        req = '{ds1620_pkg::CMD_WRITE_TL, ds1620_pkg::DIR_WRITE, 4'd9, `DS_TL_LIMIT};
      end
      ds1620_pkg::ST_READ_CONFIG: begin
        req = '{ds1620_pkg::CMD_READ_CONFIG, ds1620_pkg::DIR_READ, 4'd8, 9'd0};
      end
      ds1620_pkg::ST_POLL_READ: begin
        cmd_state = 1'b1;
      end
      default: begin
        cmd_state = 1'b0;
      end
    endcase
  end

  // One start per command state
  assign start = cmd_state && !issued && !xfer_busy;
  assign busy  = (state != ds1620_pkg::ST_POLL_WAIT) && (state != ds1620_pkg::ST_POLL_READ);

  // Only bits 0, 1, 4 and 7 are compared
  assign cfg_match = ((xfer_rdata[7:0] ^ `DS_CONFIG_VALUE) & `DS_CONFIG_MASK) == 8'h00;
  assign init_done = (state == ds1620_pkg::ST_READ_CONFIG) && xfer_done && cfg_match;

  assign status = '{busy: busy, init_ok: init_ok, temp: temp};

  //////////////////////////////////////////////////////////////////////
  // Sequence FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_32 or posedge RESET) begin
    if (RESET) begin
      state        <= ds1620_pkg::ST_RESET_WAIT;
      after_settle <= ds1620_pkg::ST_CONVERT;
      wait_cnt     <= '0;
      issued       <= 1'b0;
      init_ok      <= 1'b0;
      temp         <= '0;
      temp_valid   <= 1'b0;
    end else begin
      temp_valid <= 1'b0;
      if (start) begin
        issued <= 1'b1;
      end
      if (xfer_done) begin
        issued <= 1'b0;
      end
      if (reload && !busy) begin
        state   <= ds1620_pkg::ST_RESET_WAIT;
        init_ok <= 1'b0;
      end else begin
        case (state)
          ds1620_pkg::ST_RESET_WAIT: begin
            // A poll read may still be on the wire
            if (!xfer_busy) begin
              state <= ds1620_pkg::ST_CONFIG;
            end
          end
          ds1620_pkg::ST_CONFIG: begin
            if (xfer_done) begin
              state        <= ds1620_pkg::ST_SETTLE;
              after_settle <= ds1620_pkg::ST_CONVERT;
              wait_cnt     <= CNT_W'(SETTLE_CYC - 1);
            end
          end
          ds1620_pkg::ST_CONVERT: begin
            if (xfer_done) begin
              state <= ds1620_pkg::ST_TH;
            end
          end
          ds1620_pkg::ST_TH: begin
            if (xfer_done) begin
              state        <= ds1620_pkg::ST_SETTLE;
              after_settle <= ds1620_pkg::ST_TL;
              wait_cnt     <= CNT_W'(SETTLE_CYC - 1);
            end
          end
          ds1620_pkg::ST_TL: begin
            if (xfer_done) begin
              state        <= ds1620_pkg::ST_SETTLE;
              after_settle <= ds1620_pkg::ST_READ_CONFIG;
              wait_cnt     <= CNT_W'(SETTLE_CYC - 1);
            end
          end
          ds1620_pkg::ST_SETTLE: begin
            if (wait_cnt == '0) begin
              state <= after_settle;
            end else begin
              wait_cnt <= wait_cnt - 1'b1;
            end
          end
          ds1620_pkg::ST_READ_CONFIG: begin
            if (xfer_done) begin
              init_ok  <= init_done;
              state    <= ds1620_pkg::ST_POLL_WAIT;
              wait_cnt <= CNT_W'(POLL_CYC - 1);
            end
          end
          ds1620_pkg::ST_POLL_WAIT: begin
            // Polling stays parked after a failed readback
            if (init_ok) begin
              if (wait_cnt == '0) begin
                state <= ds1620_pkg::ST_POLL_READ;
              end else begin
                wait_cnt <= wait_cnt - 1'b1;
              end
            end
          end
          ds1620_pkg::ST_POLL_READ: begin
            if (xfer_done) begin
              temp       <= xfer_rdata;
              temp_valid <= 1'b1;
              state      <= ds1620_pkg::ST_POLL_WAIT;
              wait_cnt   <= CNT_W'(POLL_CYC - 1);
            end
          end
          default: begin
            state <= ds1620_pkg::ST_RESET_WAIT;
          end
        endcase
      end
    end
  end

endmodule

//--- source/ds1620_wire_xfer.sv
`timescale 1ns/1ps
`include "ds1620_defines.svh"

module ds1620_wire_xfer (
  input  logic                     CLK_32,
  input  logic                     RESET,
  input  logic                     start,
  input  ds1620_pkg::xfer_req_t    req,
  input  logic                     dq_in,
  output logic                     busy,
  output logic                     done,
  output logic [`DS_TEMP_BITS-1:0] rdata,
  output ds1620_pkg::wire_pins_t   pins
);

  localparam int DIV_W = $clog2(`DS_TICK_DIV);

  logic [DIV_W-1:0]         div_cnt;
  logic                     tick;
  logic [5:0]               phase;
  logic [3:0]               bits_left;
  logic [7:0]               cmd_sr;
  logic [`DS_TEMP_BITS-1:0] data_sr;
  logic [1:0]               dir_q;
  logic [3:0]               nbits_q;
  logic                     accept;
  logic                     cmd_phase;
  logic                     gap_tick;
  logic                     in_data;
  logic                     last_tick;
  logic                     low_half;

  // Free running bit tick
  assign tick = (div_cnt == DIV_W'(`DS_TICK_DIV - 1));

  always_ff @(posedge CLK_32 or posedge RESET) begin
    if (RESET) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Phase 0 raises rst, 1 to 16 carry the command byte
  assign accept    = start && !busy;
  assign cmd_phase = (phase >= 6'd1) && (phase <= 6'd16);
  assign gap_tick  = (phase == 6'd17) && (dir_q != ds1620_pkg::DIR_NONE);
  assign in_data   = (phase >= 6'd18) && (bits_left != 4'd0);
  assign last_tick = (phase >= 6'd17) && !gap_tick && !in_data;
  // Command bits start on odd phases, data bits on even ones
  assign low_half  = cmd_phase ? phase[0] : !phase[0];

  always_ff @(posedge CLK_32 or posedge RESET) begin
    if (RESET) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      phase     <= '0;
      bits_left <= '0;
      pins      <= '{rst: 1'b0, clk: 1'b1, dq_out: 1'b0, dq_oe: 1'b0};
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy      <= 1'b1;
        phase     <= '0;
        bits_left <= req.nbits;
      end else if (busy && tick) begin
        phase <= phase + 1'b1;
        if (phase == 6'd0) begin
          pins.rst <= 1'b1;
          pins.clk <= 1'b1;
        end else if (cmd_phase || in_data) begin
          pins.clk <= !low_half;
          if (low_half && (cmd_phase || dir_q == ds1620_pkg::DIR_WRITE)) begin
            pins.dq_oe  <= 1'b1;
            pins.dq_out <= cmd_phase ? cmd_sr[0] : data_sr[0];
          end
          if (!low_half && in_data) begin
            bits_left <= bits_left - 1'b1;
          end
        end else if (gap_tick) begin
          // Release DQ so the device can drive it
          pins.dq_oe <= (dir_q == ds1620_pkg::DIR_WRITE);
        end else if (last_tick) begin
          pins.rst   <= 1'b0;
          pins.dq_oe <= 1'b0;
          pins.clk   <= 1'b1;
          busy       <= 1'b0;
          done       <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK_32) begin
    if (accept) begin
      cmd_sr  <= req.cmd;
      data_sr <= req.wdata;
      dir_q   <= req.dir;
      nbits_q <= req.nbits;
    end else if (busy && tick) begin
      if (cmd_phase && low_half) begin
        cmd_sr <= cmd_sr >> 1;
      end
      if (in_data && low_half && dir_q == ds1620_pkg::DIR_WRITE) begin
        data_sr <= data_sr >> 1;
      end
      // Read bits arrive LSB first, shifted in from the top
      if (in_data && !low_half && dir_q == ds1620_pkg::DIR_READ) begin
        data_sr <= {dq_in, data_sr[`DS_TEMP_BITS-1:1]};
      end
      if (last_tick) begin
        rdata <= data_sr >> (4'(`DS_TEMP_BITS) - nbits_q);
      end
    end
  end

endmodule

//--- source/ds1620_pkg.sv
`include "ds1620_defines.svh"

package ds1620_pkg;

  typedef enum logic [7:0] {
    CMD_WRITE_CONFIG  = 8'h0C,
    CMD_START_CONVERT = 8'hEE,
    CMD_WRITE_TH      = 8'h01,
    CMD_WRITE_TL      = 8'h02,
    CMD_READ_CONFIG   = 8'hAC,
    CMD_READ_TEMP     = 8'hAA
  } ds_cmd_e;

  typedef enum logic [3:0] {
    ST_RESET_WAIT,
    ST_CONFIG,
    ST_CONVERT,
    ST_TH,
    ST_TL,
    ST_READ_CONFIG,
    ST_SETTLE,
    ST_POLL_WAIT,
    ST_POLL_READ
  } seq_state_e;

  // Data phase after the command byte
  localparam logic [1:0] DIR_NONE  = 2'd0;
  localparam logic [1:0] DIR_WRITE = 2'd1;
  localparam logic [1:0] DIR_READ  = 2'd2;

  typedef struct packed {
    ds_cmd_e                  cmd;
    logic [1:0]               dir;
    logic [3:0]               nbits;
    logic [`DS_TEMP_BITS-1:0] wdata;
  } xfer_req_t;

  typedef struct packed {
    logic rst;
    logic clk;
    logic dq_out;
    logic dq_oe;
  } wire_pins_t;

  typedef struct packed {
    logic       ack;
    logic       we;
    logic [2:0] sel;
  } host_req_t;

  typedef struct packed {
    logic                     busy;
    logic                     init_ok;
    logic [`DS_TEMP_BITS-1:0] temp;
  } status_t;

endpackage

//--- source/ds1620_defines.svh
`ifndef DS1620_DEFINES_SVH
`define DS1620_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Wire timing
//////////////////////////////////////////////////////////////////////

// CLK_32 cycles per bit tick
`define DS_TICK_DIV      16
// EEPROM settle time in ticks
`define DS_WRITE_WAIT    20000
// Ticks between temperature reads
`define DS_POLL_PERIOD   65536

//////////////////////////////////////////////////////////////////////
// Device values
//////////////////////////////////////////////////////////////////////

// CPU mode, continuous conversion
`define DS_CONFIG_VALUE  8'h0A
`define DS_CONFIG_MASK   8'h93
// 90 and 85 degrees in half degree steps
`define DS_TH_LIMIT      9'd180
`define DS_TL_LIMIT      9'd170
`define DS_HOST_SELECT   3'b110
`define DS_TEMP_BITS     9

`endif
